// File: Bender.yml
package:
  name: io_block

sources:
  # Packages first
  - hw/io_cmd_pkg.sv
  - hw/io_resp_pkg.sv
  # RTL
  - hw/led_flash.sv
  - hw/led_bank.sv
  - hw/key_debounce.sv
  - hw/radio_ctrl.sv
  - hw/resp_builder.sv
  - hw/io_block.sv
  # Testbench
  - target: test
    files:
      - tests/tb_io_block.sv

// File: filelist.f
hw/io_cmd_pkg.sv
hw/io_resp_pkg.sv
hw/led_flash.sv
hw/led_bank.sv
hw/key_debounce.sv
hw/radio_ctrl.sv
hw/resp_builder.sv
hw/io_block.sv
tests/tb_io_block.sv

// File: hw/io_block.sv
`timescale 1ns/100ps

module io_block (
  input  logic                              clk,
  input  logic                              rst_n_i,
  input  logic                              cmd_rqst_i,
  input  logic [io_cmd_pkg::CMD_ADDR_W-1:0] cmd_addr_i,
  input  logic [io_cmd_pkg::CMD_DATA_W-1:0] cmd_data_i,
  input  logic                              cmd_ptt_i,
  input  logic                              cmd_requires_resp_i,
  input  logic                              cmd_ack_ext_i,
  input  logic                              resp_rqst_i,
  input  logic                              run_i,
  input  logic                              rx_good_lvl_i,
  input  logic                              rx_clip_i,
  input  logic                              phone_tip_n_i,  // CW key
  input  logic                              phone_ring_n_i, // PTT
  input  logic                              txinhibit_n_i,
  input  logic [io_resp_pkg::TELEM_W-1:0]   fwd_pwr_i,
  input  logic [io_resp_pkg::TELEM_W-1:0]   rev_pwr_i,
  input  logic [io_resp_pkg::TELEM_W-1:0]   bias_i,
  input  logic [io_resp_pkg::TELEM_W-1:0]   temp_i,
  output logic [io_resp_pkg::RESP_W-1:0]    resp_o,
  output logic                              cw_keydown_o,
  output logic [io_cmd_pkg::LED_COUNT-1:0]  led_n_o,
  output logic                              tx_on_o,
  output logic                              pa_inttr_o,
  output logic                              pa_exttr_o,
  output logic                              pwr_envop_o,
  output logic                              pwr_envbias_o,
  output logic                              pwr_envpa_o,
  output logic                              rfsw_sel_o
);

  logic cw_key;
  logic ext_ptt;
  logic tx_inhibit;
  logic tx_on;
  logic led_rx_active;

  // Front-panel keys
  key_debounce u_deb_cw (.clk(clk), .rst_n_i(rst_n_i),
                         .key_n_i(phone_tip_n_i), .key_o(cw_key));
  key_debounce u_deb_ptt (.clk(clk), .rst_n_i(rst_n_i),
                          .key_n_i(phone_ring_n_i), .key_o(ext_ptt));
  key_debounce u_deb_inhibit (.clk(clk), .rst_n_i(rst_n_i),
                              .key_n_i(txinhibit_n_i), .key_o(tx_inhibit));

  assign cw_keydown_o = cw_key;

  radio_ctrl u_radio_ctrl (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .cmd_rqst_i    (cmd_rqst_i),
    .cmd_addr_i    (cmd_addr_i),
    .cmd_data_i    (cmd_data_i),
    .cmd_ptt_i     (cmd_ptt_i),
    .run_i         (run_i),
    .cw_key_i      (cw_key),
    .ext_ptt_i     (ext_ptt),
    .tx_inhibit_i  (tx_inhibit),
    .tx_on_o       (tx_on),
    .pa_inttr_o    (pa_inttr_o),
    .pa_exttr_o    (pa_exttr_o),
    .pwr_envop_o   (pwr_envop_o),
    .pwr_envbias_o (pwr_envbias_o),
    .pwr_envpa_o   (pwr_envpa_o),
    .rfsw_sel_o    (rfsw_sel_o)
  );

  assign tx_on_o = tx_on;

  led_bank u_led_bank (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .run_i           (run_i),
    .tx_on_i         (tx_on),
    .rx_good_lvl_i   (rx_good_lvl_i),
    .rx_clip_i       (rx_clip_i),
    .led_n_o         (led_n_o),
    .led_rx_active_o (led_rx_active)
  );

  resp_builder u_resp_builder (
    .clk                 (clk),
    .rst_n_i             (rst_n_i),
    .cmd_rqst_i          (cmd_rqst_i),
    .cmd_requires_resp_i (cmd_requires_resp_i),
    .cmd_addr_i          (cmd_addr_i),
    .cmd_data_i          (cmd_data_i),
    .cmd_ack_ext_i       (cmd_ack_ext_i),
    .resp_rqst_i         (resp_rqst_i),
    .tx_on_i             (tx_on),
    .led_rx_active_i     (led_rx_active),
    .fwd_pwr_i           (fwd_pwr_i),
    .rev_pwr_i           (rev_pwr_i),
    .bias_i              (bias_i),
    .temp_i              (temp_i),
    .resp_o              (resp_o)
  );

endmodule

// File: hw/io_cmd_pkg.sv
package io_cmd_pkg;

  // Command bus geometry
  localparam int CMD_ADDR_W = 6;
  localparam int CMD_DATA_W = 32;

  // Transceiver configuration register
  localparam logic [CMD_ADDR_W-1:0] CFG_ADDR = 6'h09;
  localparam int CFG_VNA_BIT    = 23; // VNA mode enable
  localparam int CFG_PA_EN_BIT  = 19;
  localparam int CFG_TR_DIS_BIT = 18; // T/R relay disable

  // Key debounce, sized for simulation
  localparam int DEBOUNCE_CYCLES = 16;
  localparam int DEBOUNCE_W      = 5;

  // LED prescaler, tick every 2**LED_TICK_W cycles
  localparam int LED_TICK_W = 6;
  localparam int LED_COUNT  = 4;

  // LED stretch FSM states
  localparam logic [1:0] LED_IDLE  = 2'b00;
  localparam logic [1:0] LED_LIT   = 2'b01;
  localparam logic [1:0] LED_WAIT1 = 2'b10;
  localparam logic [1:0] LED_WAIT2 = 2'b11;

endpackage

// File: hw/io_resp_pkg.sv
package io_resp_pkg;

  localparam int RESP_W    = 40;
  localparam int TELEM_W   = 12;
  localparam int PAYLOAD_W = 32;

  localparam logic [7:0] FW_SERIAL = 8'h5c;
  localparam logic [6:0] SLOT0_ID  = 7'b0001111; // Fixed firmware ID

  typedef logic [1:0] slot_t;

  // Telemetry slot rotation
  localparam slot_t SLOT_ID       = 2'd0;
  localparam slot_t SLOT_TEMP_FWD = 2'd1;
  localparam slot_t SLOT_REV_BIAS = 2'd2;
  localparam slot_t SLOT_SPARE    = 2'd3;

  // Echo of an acknowledged command, top bit set
  typedef struct packed {
    logic                              is_cmd;
    logic [io_cmd_pkg::CMD_ADDR_W-1:0] addr;
    logic                              tx_on;
    logic [io_cmd_pkg::CMD_DATA_W-1:0] data;
  } resp_cmd_t;

  // Rotating status word, top bit clear
  typedef struct packed {
    logic [2:0]           pad_hi;
    slot_t                slot;
    logic [1:0]           pad_lo;
    logic                 tx_on;
    logic [PAYLOAD_W-1:0] payload;
  } resp_status_t;

  typedef union packed {
    resp_cmd_t    cmd;
    resp_status_t status;
  } resp_word_u;

endpackage

// File: hw/key_debounce.sv
`timescale 1ns/100ps

module key_debounce (
  input  logic clk,
  input  logic rst_n_i,
  input  logic key_n_i,
  output logic key_o
);

  logic [1:0]                        sync_q;
  logic [io_cmd_pkg::DEBOUNCE_W-1:0] cnt_q;
  logic                              key_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      sync_q <= '0;
      cnt_q  <= '0;
      key_q  <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], ~key_n_i}; // Invert to active high
      if (sync_q[1] != key_q) begin
        // Flip only after a full run of differing samples
        if (cnt_q == io_cmd_pkg::DEBOUNCE_W'(io_cmd_pkg::DEBOUNCE_CYCLES - 1)) begin
          key_q <= sync_q[1];
          cnt_q <= '0;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end else begin
        cnt_q <= '0; // Agreeing sample restarts the count
      end
    end
  end

  assign key_o = key_q;

endmodule

// File: hw/led_bank.sv
`timescale 1ns/100ps

module led_bank (
  input  logic                             clk,
  input  logic                             rst_n_i,
  input  logic                             run_i,
  input  logic                             tx_on_i,
  input  logic                             rx_good_lvl_i,
  input  logic                             rx_clip_i,
  output logic [io_cmd_pkg::LED_COUNT-1:0] led_n_o,
  output logic                             led_rx_active_o
);

  logic [io_cmd_pkg::LED_TICK_W-1:0] presc_q;
  logic                              tick;
  logic [io_cmd_pkg::LED_COUNT-1:0]  led_src;

  // Free-running prescaler shared by all flashers
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      presc_q <= '0;
    end else begin
      presc_q <= presc_q + 1'b1;
    end
  end

  assign tick = &presc_q;

  assign led_src = {rx_clip_i, rx_good_lvl_i, tx_on_i, run_i}; // d5 down to d2

  for (genvar i = 0; i < io_cmd_pkg::LED_COUNT; i++) begin : g_led
    led_flash u_led_flash (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .tick_i  (tick),
      .sig_i   (led_src[i]),
      .led_n_o (led_n_o[i])
    );
  end

  // Receive activity seen while either rx LED is lit
  assign led_rx_active_o = ~led_n_o[2] | ~led_n_o[3];

endmodule

// File: hw/led_flash.sv
`timescale 1ns/100ps

module led_flash (
  input  logic clk,
  input  logic rst_n_i,
  input  logic tick_i,
  input  logic sig_i,
  output logic led_n_o
);

  logic [1:0] state_q;
  logic [1:0] state_d;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= io_cmd_pkg::LED_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Each tick walks one step back to idle, so 2 to 3 ticks lit
  always_comb begin
    state_d = state_q;
    case (state_q)
      io_cmd_pkg::LED_IDLE: begin
        if (sig_i) state_d = io_cmd_pkg::LED_LIT;
      end
      io_cmd_pkg::LED_LIT: begin
        if (tick_i) state_d = io_cmd_pkg::LED_WAIT1;
      end
      io_cmd_pkg::LED_WAIT1: begin
        if (tick_i) state_d = io_cmd_pkg::LED_WAIT2;
      end
      io_cmd_pkg::LED_WAIT2: begin
        if (tick_i) state_d = io_cmd_pkg::LED_IDLE;
      end
      default: state_d = io_cmd_pkg::LED_IDLE;
    endcase
  end

  assign led_n_o = (state_q == io_cmd_pkg::LED_IDLE); // High is off

endmodule

// File: hw/radio_ctrl.sv
`timescale 1ns/100ps

module radio_ctrl (
  input  logic                              clk,
  input  logic                              rst_n_i,
  input  logic                              cmd_rqst_i,
  input  logic [io_cmd_pkg::CMD_ADDR_W-1:0] cmd_addr_i,
  input  logic [io_cmd_pkg::CMD_DATA_W-1:0] cmd_data_i,
  input  logic                              cmd_ptt_i,
  input  logic                              run_i,
  input  logic                              cw_key_i,
  input  logic                              ext_ptt_i,
  input  logic                              tx_inhibit_i,
  output logic                              tx_on_o,
  output logic                              pa_inttr_o,
  output logic                              pa_exttr_o,
  output logic                              pwr_envop_o,
  output logic                              pwr_envbias_o,
  output logic                              pwr_envpa_o,
  output logic                              rfsw_sel_o
);

  logic ptt_q;
  logic vna_q;
  logic pa_enable_q;
  logic tr_disable_q;
  logic tx_on;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ptt_q        <= 1'b0;
      vna_q        <= 1'b0;
      pa_enable_q  <= 1'b0;
      tr_disable_q <= 1'b0;
    end else if (cmd_rqst_i) begin
      ptt_q <= cmd_ptt_i; // Every command carries PTT
      if (cmd_addr_i == io_cmd_pkg::CFG_ADDR) begin
        vna_q        <= cmd_data_i[io_cmd_pkg::CFG_VNA_BIT];
        pa_enable_q  <= cmd_data_i[io_cmd_pkg::CFG_PA_EN_BIT];
        tr_disable_q <= cmd_data_i[io_cmd_pkg::CFG_TR_DIS_BIT];
      end
    end
  end

  // Any transmit source, unless inhibited or stopped
  assign tx_on = (ptt_q | cw_key_i | ext_ptt_i | vna_q) & ~tx_inhibit_i & run_i;

  assign tx_on_o = tx_on;

  // Internal T/R relay stays in use when the PA is bypassed
  assign pa_inttr_o = tx_on & (pa_enable_q | ~tr_disable_q);
  assign pa_exttr_o = tx_on;

  assign pwr_envop_o   = tx_on;
  assign pwr_envbias_o = tx_on & pa_enable_q;
  assign pwr_envpa_o   = tx_on & pa_enable_q;

  assign rfsw_sel_o = pa_enable_q; // Route RF through the PA

endmodule

// File: hw/resp_builder.sv
`timescale 1ns/100ps

module resp_builder (
  input  logic                               clk,
  input  logic                               rst_n_i,
  input  logic                               cmd_rqst_i,
  input  logic                               cmd_requires_resp_i,
  input  logic [io_cmd_pkg::CMD_ADDR_W-1:0]  cmd_addr_i,
  input  logic [io_cmd_pkg::CMD_DATA_W-1:0]  cmd_data_i,
  input  logic                               cmd_ack_ext_i,
  input  logic                               resp_rqst_i,
  input  logic                               tx_on_i,
  input  logic                               led_rx_active_i,
  input  logic [io_resp_pkg::TELEM_W-1:0]    fwd_pwr_i,
  input  logic [io_resp_pkg::TELEM_W-1:0]    rev_pwr_i,
  input  logic [io_resp_pkg::TELEM_W-1:0]    bias_i,
  input  logic [io_resp_pkg::TELEM_W-1:0]    temp_i,
  output logic [io_resp_pkg::RESP_W-1:0]     resp_o
);

  logic [io_cmd_pkg::CMD_ADDR_W-1:0] cap_addr_q;
  logic [io_cmd_pkg::CMD_DATA_W-1:0] cap_data_q;
  logic                              requires_q;
  logic [io_cmd_pkg::CMD_ADDR_W-1:0] echo_addr_q;
  logic [io_cmd_pkg::CMD_DATA_W-1:0] echo_data_q;
  logic                              pending_q;
  io_resp_pkg::slot_t                slot_q;
  io_resp_pkg::resp_word_u           resp_q;
  logic                              cmd_ack;

  // Telemetry sits in the low bits of a 16-bit half
  function automatic logic [15:0] pad_telem(input logic [io_resp_pkg::TELEM_W-1:0] val);
    return 16'(val);
  endfunction

  always_ff @(posedge clk) begin
    if (cmd_rqst_i) begin
      cap_addr_q <= cmd_addr_i;
      cap_data_q <= cmd_data_i;
    end
    if (cmd_ack) begin
      echo_addr_q <= cap_addr_q; // One-deep queue, newest ack wins
      echo_data_q <= cap_data_q;
    end
  end

  assign cmd_ack = requires_q & cmd_ack_ext_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      requires_q <= 1'b0;
      pending_q  <= 1'b0;
      slot_q     <= io_resp_pkg::SLOT_ID;
      resp_q     <= '0;
    end else begin
      if (cmd_rqst_i) requires_q <= cmd_requires_resp_i;

      if (cmd_ack) begin
        pending_q <= 1'b1;
      end else if (resp_rqst_i) begin
        pending_q <= 1'b0;
      end

      if (resp_rqst_i) begin
        slot_q <= slot_q + 1'b1; // Echo still consumes a slot
        if (pending_q) begin
          resp_q.cmd.is_cmd <= 1'b1;
          resp_q.cmd.addr   <= echo_addr_q;
          resp_q.cmd.tx_on  <= tx_on_i;
          resp_q.cmd.data   <= echo_data_q;
        end else begin
          resp_q.status.pad_hi <= '0;
          resp_q.status.slot   <= slot_q;
          resp_q.status.pad_lo <= '0;
          resp_q.status.tx_on  <= tx_on_i;
          case (slot_q)
            io_resp_pkg::SLOT_ID:
              resp_q.status.payload <= {io_resp_pkg::SLOT0_ID, led_rx_active_i,
                                        16'h0000, io_resp_pkg::FW_SERIAL};
            io_resp_pkg::SLOT_TEMP_FWD:
              resp_q.status.payload <= {pad_telem(temp_i), pad_telem(fwd_pwr_i)};
            io_resp_pkg::SLOT_REV_BIAS:
              resp_q.status.payload <= {pad_telem(rev_pwr_i), pad_telem(bias_i)};
            io_resp_pkg::SLOT_SPARE:
              resp_q.status.payload <= '0;
            default:
              resp_q.status.payload <= '0;
          endcase
        end
      end
    end
  end

  assign resp_o = resp_q;

endmodule

// File: tests/tb_io_block.sv
`timescale 1ns/100ps

module tb_io_block;

  localparam int TICK_CYCLES   = 2 ** io_cmd_pkg::LED_TICK_W;
  localparam int SETTLE_CYCLES = io_cmd_pkg::DEBOUNCE_CYCLES + 3;

  logic                              clk;
  logic                              rst_n_i;
  logic                              cmd_rqst_i;
  logic [io_cmd_pkg::CMD_ADDR_W-1:0] cmd_addr_i;
  logic [io_cmd_pkg::CMD_DATA_W-1:0] cmd_data_i;
  logic                              cmd_ptt_i;
  logic                              cmd_requires_resp_i;
  logic                              cmd_ack_ext_i;
  logic                              resp_rqst_i;
  logic                              run_i;
  logic                              rx_good_lvl_i;
  logic                              rx_clip_i;
  logic                              phone_tip_n_i;
  logic                              phone_ring_n_i;
  logic                              txinhibit_n_i;
  logic [io_resp_pkg::TELEM_W-1:0]   fwd_pwr_i;
  logic [io_resp_pkg::TELEM_W-1:0]   rev_pwr_i;
  logic [io_resp_pkg::TELEM_W-1:0]   bias_i;
  logic [io_resp_pkg::TELEM_W-1:0]   temp_i;
  logic [io_resp_pkg::RESP_W-1:0]    resp_o;
  logic                              cw_keydown_o;
  logic [3:0]                        led_n_o;
  logic                              tx_on_o;
  logic                              pa_inttr_o;
  logic                              pa_exttr_o;
  logic                              pwr_envop_o;
  logic                              pwr_envbias_o;
  logic                              pwr_envpa_o;
  logic                              rfsw_sel_o;

  // Reference model state
  logic [31:0] rng;
  logic        exp_ptt, exp_vna, exp_pa_en, exp_tr_dis, exp_run;
  logic        exp_cw, exp_ext, exp_inh;
  logic        exp_requires, exp_pending;
  logic [5:0]  last_addr, echo_addr, addr;
  logic [31:0] last_data, echo_data, data;
  logic [1:0]  exp_slot;
  int          cycle_cnt;

  io_block UUT (
    .clk                 (clk),
    .rst_n_i             (rst_n_i),
    .cmd_rqst_i          (cmd_rqst_i),
    .cmd_addr_i          (cmd_addr_i),
    .cmd_data_i          (cmd_data_i),
    .cmd_ptt_i           (cmd_ptt_i),
    .cmd_requires_resp_i (cmd_requires_resp_i),
    .cmd_ack_ext_i       (cmd_ack_ext_i),
    .resp_rqst_i         (resp_rqst_i),
    .run_i               (run_i),
    .rx_good_lvl_i       (rx_good_lvl_i),
    .rx_clip_i           (rx_clip_i),
    .phone_tip_n_i       (phone_tip_n_i),
    .phone_ring_n_i      (phone_ring_n_i),
    .txinhibit_n_i       (txinhibit_n_i),
    .fwd_pwr_i           (fwd_pwr_i),
    .rev_pwr_i           (rev_pwr_i),
    .bias_i              (bias_i),
    .temp_i              (temp_i),
    .resp_o              (resp_o),
    .cw_keydown_o        (cw_keydown_o),
    .led_n_o             (led_n_o),
    .tx_on_o             (tx_on_o),
    .pa_inttr_o          (pa_inttr_o),
    .pa_exttr_o          (pa_exttr_o),
    .pwr_envop_o         (pwr_envop_o),
    .pwr_envbias_o       (pwr_envbias_o),
    .pwr_envpa_o         (pwr_envpa_o),
    .rfsw_sel_o          (rfsw_sel_o)
  );

  always #20 clk = ~clk; // 40 ns period

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  task automatic fail_with(input string msg);
    $display("Fail at %0t: %s", $time, msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic stop_on_timeout(input string msg);
    $display("Timeout at %0t: %s", $time, msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic tx_expected();
    return (exp_ptt | exp_cw | exp_ext | exp_vna) & ~exp_inh & exp_run;
  endfunction

  // Response holds between requests
  assert property (@(posedge clk) disable iff (!rst_n_i) !resp_rqst_i |=> $stable(resp_o))
    else fail_with("resp_o changed without a response request");

  task automatic check_ctrl(input string where);
    logic tx;
    tx = tx_expected();
    assert (tx_on_o == tx)
      else fail_with($sformatf("%s: tx_on_o=%b expected %b", where, tx_on_o, tx));
    assert (pa_exttr_o == tx && pwr_envop_o == tx)
      else fail_with($sformatf("%s: pa_exttr_o or pwr_envop_o wrong", where));
    assert (pa_inttr_o == (tx & (exp_pa_en | ~exp_tr_dis)))
      else fail_with($sformatf("%s: pa_inttr_o=%b wrong", where, pa_inttr_o));
    assert (pwr_envbias_o == (tx & exp_pa_en) && pwr_envpa_o == (tx & exp_pa_en))
      else fail_with($sformatf("%s: PA supply enables wrong", where));
    assert (rfsw_sel_o == exp_pa_en)
      else fail_with($sformatf("%s: rfsw_sel_o=%b expected %b", where, rfsw_sel_o, exp_pa_en));
  endtask

  task automatic send_cmd(input logic [5:0] a, input logic [31:0] d, input logic ptt,
                          input logic req, input logic run);
    @(negedge clk);
    cmd_rqst_i          = 1'b1;
    cmd_addr_i          = a;
    cmd_data_i          = d;
    cmd_ptt_i           = ptt;
    cmd_requires_resp_i = req;
    run_i               = run;
    @(negedge clk);
    exp_run      = run;
    exp_ptt      = ptt;
    exp_requires = req;
    last_addr    = a;
    last_data    = d;
    if (a == 6'd9) begin // Config register
      exp_vna    = d[23];
      exp_pa_en  = d[19];
      exp_tr_dis = d[18];
    end
    check_ctrl("after command");
    cmd_rqst_i = 1'b0;
  endtask

  task automatic ack_cmd();
    @(negedge clk);
    cmd_ack_ext_i = 1'b1;
    @(negedge clk);
    cmd_ack_ext_i = 1'b0;
    if (exp_requires) begin
      exp_pending = 1'b1;
      echo_addr   = last_addr;
      echo_data   = last_data;
    end
  endtask

  task automatic request_resp(input logic rx_act);
    logic [39:0] exp_word;
    logic [31:0] payload;
    @(negedge clk);
    resp_rqst_i = 1'b1;
    @(negedge clk);
    if (exp_pending) begin
      exp_word = {1'b1, echo_addr, tx_expected(), echo_data};
    end else begin
      case (exp_slot)
        2'd0:    payload = {7'b0001111, rx_act, 16'h0000, io_resp_pkg::FW_SERIAL};
        2'd1:    payload = {4'h0, temp_i, 4'h0, fwd_pwr_i};
        2'd2:    payload = {4'h0, rev_pwr_i, 4'h0, bias_i};
        default: payload = 32'h0;
      endcase
      exp_word = {3'b000, exp_slot, 2'b00, tx_expected(), payload};
    end
    assert (resp_o === exp_word)
      else fail_with($sformatf("resp_o=%h expected %h", resp_o, exp_word));
    resp_rqst_i = 1'b0;
    exp_pending = 1'b0;
    exp_slot    = exp_slot + 2'd1; // An echo also uses up a slot
  endtask

  task automatic set_keys(input logic cw, input logic ptt, input logic inh);
    @(negedge clk);
    phone_tip_n_i  = ~cw;
    phone_ring_n_i = ~ptt;
    txinhibit_n_i  = ~inh;
    for (int i = 0; i < SETTLE_CYCLES; i++) @(negedge clk);
    exp_cw  = cw;
    exp_ext = ptt;
    exp_inh = inh;
    assert (cw_keydown_o == cw) else fail_with("cw_keydown_o did not follow the held key");
    check_ctrl("after key change");
  endtask

  task automatic pulse_cw_key(input int len);
    for (int i = 0; i < len + SETTLE_CYCLES; i++) begin
      @(negedge clk);
      assert (cw_keydown_o == 1'b0) else fail_with("short CW pulse reached cw_keydown_o");
      phone_tip_n_i = (i < len) ? 1'b0 : 1'b1;
    end
  endtask

  task automatic press_cw_key();
    int waited;
    @(negedge clk);
    phone_tip_n_i = 1'b0;
    waited = 0;
    while (cw_keydown_o !== 1'b1) begin
      if (waited == SETTLE_CYCLES) stop_on_timeout("held CW key never set cw_keydown_o");
      @(negedge clk);
      waited++;
    end
    exp_cw = 1'b1;
  endtask

  task automatic flash_clip_led();
    int c0;
    @(negedge clk);
    rx_clip_i = 1'b1;
    @(negedge clk);
    rx_clip_i = 1'b0;
    c0 = cycle_cnt;
    assert (led_n_o[3] == 1'b0) else fail_with("clip LED not lit one cycle after pulse");
    while (exp_slot != 2'd0) request_resp(1'b1);
    request_resp(1'b1); // Slot 0 carries the rx-active bit
    while (led_n_o[3] == 1'b0) begin
      if (cycle_cnt - c0 > 4 * TICK_CYCLES) stop_on_timeout("clip LED never turned off");
      @(negedge clk);
    end
    assert (cycle_cnt - c0 >= 2 * TICK_CYCLES && cycle_cnt - c0 <= 3 * TICK_CYCLES + 1)
      else fail_with($sformatf("clip LED lit for %0d cycles", cycle_cnt - c0));
  endtask

  initial begin
    clk = 1'b0;
    cycle_cnt = 0;
    rst_n_i = 1'b0;
    {cmd_rqst_i, cmd_ptt_i, cmd_requires_resp_i, cmd_ack_ext_i, resp_rqst_i} = '0;
    cmd_addr_i = '0;
    cmd_data_i = '0;
    {run_i, rx_good_lvl_i, rx_clip_i} = '0;
    {phone_tip_n_i, phone_ring_n_i, txinhibit_n_i} = 3'b111; // Keys released
    {fwd_pwr_i, rev_pwr_i, bias_i, temp_i} = '0;
    rng = 32'h04a1d343;
    {exp_ptt, exp_vna, exp_pa_en, exp_tr_dis, exp_run} = '0;
    {exp_cw, exp_ext, exp_inh, exp_requires, exp_pending} = '0;
    exp_slot = 2'd0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    @(negedge clk);

    assert (led_n_o == 4'hf) else fail_with("LEDs not off after reset");
    assert (resp_o == '0) else fail_with("resp_o not zero after reset");
    check_ctrl("after reset");

    // Random config, PTT, run and key states
    for (int k = 0; k < 6; k++) begin
      rng = xorshift(rng);
      set_keys(rng[0], rng[1], rng[2] & rng[3]);
      for (int j = 0; j < 6; j++) begin
        rng  = xorshift(rng);
        data = xorshift(rng ^ 32'h9e3779b9);
        addr = rng[8] ? 6'd9 : rng[5:0];
        send_cmd(addr, data, rng[9], 1'b0, rng[10] | rng[11]);
      end
    end

    // Debounce and inhibit
    set_keys(1'b0, 1'b0, 1'b0);
    send_cmd(6'd9, 32'h0, 1'b0, 1'b0, 1'b1);
    pulse_cw_key(io_cmd_pkg::DEBOUNCE_CYCLES - 1);
    press_cw_key();
    check_ctrl("CW key held");
    set_keys(1'b1, 1'b0, 1'b1);
    set_keys(1'b0, 1'b0, 1'b0);

    // Telemetry rotation
    rng = xorshift(rng);
    fwd_pwr_i = rng[11:0];
    rev_pwr_i = rng[23:12];
    rng = xorshift(rng);
    bias_i = rng[11:0];
    temp_i = rng[23:12];
    while (exp_slot != 2'd0) request_resp(1'b0);
    for (int n = 0; n < 5; n++) request_resp(1'b0);

    flash_clip_led();

    // Command echo and the slot it takes
    send_cmd(6'h2a, 32'hc0de_1234, 1'b1, 1'b1, 1'b1);
    ack_cmd();
    request_resp(1'b0);
    request_resp(1'b0);
    send_cmd(6'h15, 32'h0bad_f00d, 1'b0, 1'b0, 1'b1);
    ack_cmd();
    request_resp(1'b0);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
